//--- Makefile
# Verilator build and run for the QSPI manager testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module qspi_manager_tb \
		-f project.f -Mdir obj_dir -o qspi_manager_tb

# The log decides the result, whatever the simulator's exit status
run: compile
	./obj_dir/qspi_manager_tb +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Simulation finished: PASS" $(LOG) || { echo "Test failed, see $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

//--- project.f
source/qspi_wire_pkg.sv
source/qspi_cmd_pkg.sv
source/qspi_frame_engine.sv
source/qspi_command_sequencer.sv
source/qspi_manager.sv
sim/qspi_clock_gen.sv
sim/genx_qspi_target.sv
sim/qspi_manager_properties.sv
sim/qspi_manager_tb.sv

//--- sim/genx_qspi_target.sv
// Behavioral GenX QSPI receiver: host and bank registers, frame decode, miso drive
`timescale 1ns/1ns

module genx_qspi_target (
    input  logic       sck,
    input  logic       host_csn,
    input  logic       bank_csn,
    input  logic [3:0] mosi,
    output logic [3:0] miso
);

    import qspi_wire_pkg::*;
    import qspi_cmd_pkg::*;

    // Nybble positions inside a frame
    localparam int OPCODE_END      = OPCODE_NYBBLES;
    localparam int ADDR_END        = OPCODE_END + ADDR_NYBBLES;
    localparam int WDATA_END       = ADDR_END + DATA_NYBBLES;
    localparam int READ_DATA_START = ADDR_END + TAT_NYBBLES;

    // Address bits 4:2 pick the slot, so 0x28 shares slot 2 with 0x08
    localparam logic [2:0] EN_SLOT = BANK_EN_REG[4:2];

    logic [31:0] host_regs [8];
    logic [31:0] bank_regs [BANK_COUNT][8];

    logic        frame_on_bank = 1'b0;
    int          nybble_count  = 0;
    logic [7:0]  opcode        = 8'h0;
    logic [31:0] addr_wire     = 32'h0;
    logic [31:0] data_wire     = 32'h0;
    logic [3:0]  miso_nybble   = 4'h0;

    wire cs_n = host_csn & bank_csn;

    assign miso = miso_nybble;

    // Every register starts with a value that names its bank and slot
    initial begin
        for (int s = 0; s < 8; s++) begin
            host_regs[s] = 32'h4000_0000 | 32'(s * 4);
            for (int b = 0; b < BANK_COUNT; b++) begin
                bank_regs[b][s] = 32'hB000_0000 | 32'(b << 8) | 32'(s * 4);
            end
        end
    end

    // Wire words are little-endian
    function automatic logic [31:0] reverse_bytes(input logic [31:0] word);
        return {word[7:0], word[15:8], word[23:16], word[31:24]};
    endfunction

    // A bank read answers from the lowest enabled bank
    function automatic logic [31:0] read_value(input logic on_bank, input logic [2:0] slot);
        logic [31:0] value;
        value = on_bank ? 32'h0 : host_regs[slot];
        if (on_bank) begin
            for (int b = BANK_COUNT - 1; b >= 0; b--) begin
                if (host_regs[EN_SLOT][b]) begin
                    value = bank_regs[b][slot];
                end
            end
        end
        return value;
    endfunction

    // Collect nybbles on rising sck and commit a write when the chip select rises
    always @(posedge sck or posedge cs_n) begin : decode_frame
        logic [31:0] address;
        logic [31:0] value;
        address = reverse_bytes(addr_wire);
        value   = reverse_bytes(data_wire);
        if (cs_n) begin
            if (nybble_count == WDATA_END && opcode == OPCODE_WRITE_SINGLE) begin
                if (frame_on_bank) begin
                    for (int b = 0; b < BANK_COUNT; b++) begin
                        if (host_regs[EN_SLOT][b]) begin
                            bank_regs[b][address[4:2]] = value;
                        end
                    end
                end else begin
                    host_regs[address[4:2]] = value;
                end
            end
            nybble_count = 0;
        end else begin
            frame_on_bank = !bank_csn;
            if (nybble_count < OPCODE_END) begin
                opcode = {opcode[6:0], mosi[0]};
            end else if (nybble_count < ADDR_END) begin
                addr_wire = {addr_wire[27:0], mosi};
            end else if (nybble_count < WDATA_END) begin
                data_wire = {data_wire[27:0], mosi};
            end
            nybble_count = nybble_count + 1;
        end
    end

    // Read data goes out on falling sck, one nybble ahead of the manager's sample
    always @(negedge sck) begin : drive_miso
        logic [31:0] address;
        logic [31:0] wire_word;
        int          index;
        address   = reverse_bytes(addr_wire);
        wire_word = reverse_bytes(read_value(frame_on_bank, address[4:2]));
        index     = nybble_count - READ_DATA_START;
        if (!cs_n && opcode == OPCODE_READ_SINGLE && index >= 0 && index < DATA_NYBBLES) begin
            miso_nybble <= wire_word[31 - 4 * index -: 4];
        end else begin
            miso_nybble <= 4'h0;
        end
    end

endmodule

//--- sim/qspi_clock_gen.sv
// Testbench clock and reset generator
`timescale 1ns/1ns

module qspi_clock_gen #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // Reset is released on a falling edge, away from the DUT's sampling edge
    initial begin
        resetn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

//--- sim/qspi_manager_properties.sv
// Pin protocol assertions for the QSPI frame engine
`timescale 1ns/1ns

module qspi_manager_properties (
    input logic       clk,
    input logic       resetn,
    input logic       sck,
    input logic [3:0] mosi,
    input logic       host_csn,
    input logic       bank_csn
);

    // Number of failed assertions, read back by the testbench
    int unsigned failure_count = 0;

    // Only one device is selected at a time
    cs_exclusive: assert property (
        @(posedge clk) disable iff (!resetn) host_csn || bank_csn
    ) else begin
        $error("host_csn and bank_csn are low together");
        failure_count++;
    end

    // No clock edges reach the bus outside a frame
    sck_quiet: assert property (
        @(posedge clk) disable iff (!resetn) (host_csn && bank_csn) |-> !sck
    ) else begin
        $error("sck is high while no chip select is active");
        failure_count++;
    end

    // mosi only moves on the falling edge, so it holds while sck is high
    mosi_hold: assert property (
        @(posedge clk) disable iff (!resetn) sck |-> $stable(mosi)
    ) else begin
        $error("mosi changed while sck was high");
        failure_count++;
    end

endmodule

//--- sim/qspi_manager_tb.sv
// QSPI manager testbench: directed and random commands checked against a
// register model, compare tasks, watchdog and verdict
`timescale 1ns/1ns

module qspi_manager_tb;

    import qspi_wire_pkg::*;
    import qspi_cmd_pkg::*;

    localparam int CLK_PERIOD_NS = 10;
    localparam int RANDOM_CMDS   = 200;
    localparam int DIRECTED_CMDS = 9;
    // A bank read is two frames of about 160 clocks together
    localparam int CLKS_PER_CMD  = 200;
    localparam int TIMEOUT_NS    = (RANDOM_CMDS + DIRECTED_CMDS) * CLKS_PER_CMD * CLK_PERIOD_NS;

    localparam logic [2:0] EN_SLOT = BANK_EN_REG[4:2];

    logic       clk;
    logic       resetn;
    qspi_req_t  req;
    qspi_rsp_t  rsp;
    logic [3:0] mosi;
    logic [3:0] miso;
    logic       sck;
    logic       host_csn;
    logic       bank_csn;

    // Register model and bookkeeping
    logic [31:0] host_model [8];
    logic [31:0] bank_model [BANK_COUNT][8];
    logic [31:0] last_rdata;
    integer      seed = 32'h92a1;
    int          check_count = 0;
    int          error_count = 0;

    qspi_clock_gen #(.period_ns(CLK_PERIOD_NS), .reset_cycles(3)) clock_gen_i (
        .clk    (clk),
        .resetn (resetn)
    );

    qspi_manager qspi_manager_i (
        .clk      (clk),
        .resetn   (resetn),
        .req      (req),
        .rsp      (rsp),
        .mosi     (mosi),
        .miso     (miso),
        .sck      (sck),
        .host_csn (host_csn),
        .bank_csn (bank_csn)
    );

    genx_qspi_target target_i (
        .sck      (sck),
        .host_csn (host_csn),
        .bank_csn (bank_csn),
        .mosi     (mosi),
        .miso     (miso)
    );

    bind qspi_frame_engine qspi_manager_properties properties_i (
        .clk      (clk),
        .resetn   (resetn),
        .sck      (sck),
        .mosi     (mosi),
        .host_csn (host_csn),
        .bank_csn (bank_csn)
    );

    // ============================================================
    // Compare tasks
    // ============================================================

    task automatic check_rsp(input string name, input qspi_rsp_t expected, input qspi_rsp_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s expected idle=0x%0h rdata=0x%08h actual idle=0x%0h rdata=0x%08h",
                     name, expected.idle, expected.rdata, actual.idle, actual.rdata);
        end
    endtask

    task automatic check_rdata(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic check_pin(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic report_counts;
        $display("Checks: %0d  errors: %0d  assertion failures: %0d", check_count, error_count,
                 qspi_manager_i.qspi_frame_engine_i.properties_i.failure_count);
    endtask

    // ============================================================
    // Reference model and command driver
    // ============================================================

    // Bank commands first rewrite the bank-enable register with the bankmap
    task automatic apply_to_model(input qspi_cmd_t cmd, input logic [BANK_COUNT-1:0] bankmap,
                                  input logic [31:0] addr, input logic [31:0] wdata,
                                  output logic [31:0] read_value);
        logic [2:0] slot;
        slot       = addr[4:2];
        read_value = 32'h0;
        if (cmd == wr_breg || cmd == rd_breg) begin
            host_model[EN_SLOT] = {{(32 - BANK_COUNT){1'b0}}, bankmap};
        end
        case (cmd)
            wr_hreg: host_model[slot] = wdata;
            rd_hreg: read_value = host_model[slot];
            wr_breg: begin
                for (int b = 0; b < BANK_COUNT; b++) begin
                    if (bankmap[b]) begin
                        bank_model[b][slot] = wdata;
                    end
                end
            end
            rd_breg: begin
                for (int b = BANK_COUNT - 1; b >= 0; b--) begin
                    if (bankmap[b]) begin
                        read_value = bank_model[b][slot];
                    end
                end
            end
        endcase
    endtask

    // Returns on a falling edge with rsp.idle high; the watchdog bounds the wait
    task automatic wait_for_idle;
        @(negedge clk);
        while (!rsp.idle) begin
            @(negedge clk);
        end
    endtask

    task automatic run_command(input qspi_cmd_t cmd, input logic [BANK_COUNT-1:0] bankmap,
                               input logic [31:0] addr, input logic [31:0] wdata,
                               input logic poke_busy);
        logic [31:0] expected_read;
        qspi_rsp_t   expected_rsp;
        wait_for_idle();
        req.start   = 1'b1;
        req.cmd     = cmd;
        req.bankmap = bankmap;
        req.addr    = addr;
        req.wdata   = wdata;
        apply_to_model(cmd, bankmap, addr, wdata, expected_read);
        @(negedge clk);
        req.start = 1'b0;
        @(negedge clk);
        expected_rsp.idle  = 1'b0;
        expected_rsp.rdata = last_rdata;
        check_rsp("rsp while busy", expected_rsp, rsp);
        if (poke_busy) begin
            // A strobe while busy is dropped, so the model sees nothing
            req.start = 1'b1;
            req.cmd   = wr_hreg;
            req.addr  = 32'h0;
            req.wdata = ~wdata;
            @(negedge clk);
            req.start = 1'b0;
        end
        wait_for_idle();
        if (cmd == rd_hreg || cmd == rd_breg) begin
            last_rdata = expected_read;
            check_rdata("rsp.rdata", expected_read, rsp.rdata);
        end
        expected_rsp.idle  = 1'b1;
        expected_rsp.rdata = last_rdata;
        check_rsp("rsp after command", expected_rsp, rsp);
        check_pin("host_csn", 1'b1, host_csn);
        check_pin("bank_csn", 1'b1, bank_csn);
        check_pin("sck", 1'b0, sck);
    endtask

    // ============================================================
    // Stimulus
    // ============================================================

    initial begin : stimulus
        logic [31:0]           rnd;
        logic [31:0]           addr;
        logic [31:0]           wdata;
        logic [BANK_COUNT-1:0] bankmap;
        qspi_cmd_t             cmd;
        qspi_rsp_t             expected_rsp;
        req        = '0;
        last_rdata = 32'h0;
        // Same start values as the receiver model
        for (int s = 0; s < 8; s++) begin
            host_model[s] = 32'h4000_0000 | 32'(s * 4);
            for (int b = 0; b < BANK_COUNT; b++) begin
                bank_model[b][s] = 32'hB000_0000 | 32'(b << 8) | 32'(s * 4);
            end
        end

        @(posedge resetn);
        @(negedge clk);
        expected_rsp.idle  = 1'b1;
        expected_rsp.rdata = 32'h0;
        check_rsp("rsp after reset", expected_rsp, rsp);
        check_pin("host_csn", 1'b1, host_csn);
        check_pin("bank_csn", 1'b1, bank_csn);
        check_pin("sck", 1'b0, sck);

        // Host write and read back
        wdata = $random(seed);
        run_command(wr_hreg, '0, 32'h14, wdata, 1'b0);
        run_command(rd_hreg, '0, 32'h14, 32'h0, 1'b0);

        // Write banks 0 and 2 together, then read every bank alone
        wdata = $random(seed);
        run_command(wr_breg, 4'b0101, 32'h0C, wdata, 1'b0);
        for (int b = 0; b < BANK_COUNT; b++) begin
            run_command(rd_breg, BANK_COUNT'(1) << b, 32'h0C, 32'h0, 1'b0);
        end

        // Bank-enable register holds the last bankmap
        run_command(rd_hreg, '0, BANK_EN_REG, 32'h0, 1'b1);

        // The strobe given during that read must not have reached host register 0
        run_command(rd_hreg, '0, 32'h0, 32'h0, 1'b0);

        for (int n = 0; n < RANDOM_CMDS; n++) begin
            rnd = $random(seed);
            cmd = qspi_cmd_t'(rnd[1:0]);
            if (rnd[5:2] == 4'h0) begin
                addr = BANK_EN_REG;
            end else begin
                addr = {27'h0, rnd[8:6], 2'b00};
            end
            bankmap = rnd[14:11];
            if (cmd == rd_breg || bankmap == '0) begin
                bankmap = BANK_COUNT'(1) << rnd[10:9];
            end
            wdata = $random(seed);
            run_command(cmd, bankmap, addr, wdata, rnd[20:18] == 3'h0);
        end

        report_counts();
        if (error_count == 0 &&
            qspi_manager_i.qspi_frame_engine_i.properties_i.failure_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("ERROR: no verdict after %0d ns, the DUT stopped returning to idle",
                 TIMEOUT_NS);
        report_counts();
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- source/qspi_cmd_pkg.sv
// Client-side command codes and the request and response structs
package qspi_cmd_pkg;

    // Commands the manager carries out
    typedef enum logic [1:0] {
        wr_hreg = 2'd0,
        rd_hreg = 2'd1,
        wr_breg = 2'd2,
        rd_breg = 2'd3
    } qspi_cmd_t;

    // Number of banks on the GenX part, one bankmap bit each
    localparam int BANK_COUNT = 4;

    // Request from the client
    // start is a one-cycle strobe and the other fields are sampled with it
    typedef struct packed {
        logic                  start;
        qspi_cmd_t             cmd;
        logic [BANK_COUNT-1:0] bankmap;
        logic [31:0]           addr;
        logic [31:0]           wdata;
    } qspi_req_t;

    // Response to the client
    // idle high means a new start is accepted, rdata holds the last read
    typedef struct packed {
        logic        idle;
        logic [31:0] rdata;
    } qspi_rsp_t;

endpackage

//--- source/qspi_command_sequencer.sv
// Command sequencer: turns a client command into a bank-select frame and a
// command frame, and returns read data
`timescale 1ns/1ns

module qspi_command_sequencer (
    input  logic                       clk,
    input  logic                       resetn,
    input  qspi_cmd_pkg::qspi_req_t    req,
    output qspi_cmd_pkg::qspi_rsp_t    rsp,
    output qspi_wire_pkg::qspi_frame_t frame,
    output logic                       frame_start,
    input  logic                       frame_idle,
    input  logic [31:0]                read_word
);

    import qspi_wire_pkg::*;
    import qspi_cmd_pkg::*;

    typedef enum logic [1:0] {
        seq_idle,
        seq_bank_select,
        seq_issue,
        seq_wait_end
    } seq_state_t;

    seq_state_t state;

    // Request fields latched with start
    qspi_cmd_t             cmd_q;
    logic [BANK_COUNT-1:0] bankmap_q;
    logic [31:0]           addr_q;
    logic [31:0]           wdata_q;

    logic [31:0] rdata_q;

    // Decoded command properties
    logic cmd_is_bank;
    logic cmd_is_read;

    always_comb begin
        cmd_is_bank = (cmd_q == wr_breg) || (cmd_q == rd_breg);
        cmd_is_read = (cmd_q == rd_hreg) || (cmd_q == rd_breg);
    end

    // Idle drops in the same cycle as start, so a second strobe is never taken
    always_comb begin
        rsp.idle  = (state == seq_idle) && !req.start;
        rsp.rdata = rdata_q;
    end

    // ============================================================
    // Command state machine
    // ============================================================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= seq_idle;
            frame_start <= 1'b0;
            rdata_q     <= '0;
        end else begin
            // One-cycle strobe to the engine
            frame_start <= 1'b0;

            case (state)
                seq_idle: begin
                    if (req.start) begin
                        cmd_q     <= req.cmd;
                        bankmap_q <= req.bankmap;
                        addr_q    <= req.addr;
                        wdata_q   <= req.wdata;
                        if ((req.cmd == wr_breg) || (req.cmd == rd_breg)) begin
                            state <= seq_bank_select;
                        end else begin
                            state <= seq_issue;
                        end
                    end
                end

                // Write the bank map into the bank-enable host register
                // The engine byte-swaps the word on the wire
                seq_bank_select: begin
                    if (frame_idle) begin
                        frame <= '{target:  cs_host,
                                   is_read: 1'b0,
                                   address: BANK_EN_REG,
                                   wdata:   {{(32-BANK_COUNT){1'b0}}, bankmap_q}};
                        frame_start <= 1'b1;
                        state       <= seq_issue;
                    end
                end

                // The command frame itself, waiting out a bank-select frame first
                seq_issue: begin
                    if (frame_idle) begin
                        frame <= '{target:  cmd_is_bank ? cs_bank : cs_host,
                                   is_read: cmd_is_read,
                                   address: addr_q,
                                   wdata:   wdata_q};
                        frame_start <= 1'b1;
                        state       <= seq_wait_end;
                    end
                end

                // Engine back in idle means the frame and its hold time are done
                seq_wait_end: begin
                    if (frame_idle) begin
                        if (cmd_is_read) begin
                            rdata_q <= read_word;
                        end
                        state <= seq_idle;
                    end
                end

                default: state <= seq_idle;
            endcase
        end
    end

endmodule

//--- source/qspi_frame_engine.sv
// QSPI frame engine: one frame from chip-select assertion to release,
// with sck timing, mosi shifting and miso capture
`timescale 1ns/1ns

module qspi_frame_engine #(
    parameter int clk_freq_hz = 100_000_000,
    parameter int sck_freq_hz = 50_000_000
) (
    input  logic                      clk,
    input  logic                      resetn,
    input  qspi_wire_pkg::qspi_frame_t frame,
    input  logic                      frame_start,
    output logic                      frame_idle,
    output logic [31:0]               read_word,
    output logic                      sck,
    output logic [3:0]                mosi,
    input  logic [3:0]                miso,
    output logic                      host_csn,
    output logic                      bank_csn
);

    import qspi_wire_pkg::*;

    // ============================================================
    // Derived timing
    // ============================================================

    localparam int NS_PER_CLK = 1_000_000_000 / clk_freq_hz;

    // Chip-select delay, rounded up so the setup and hold time is always met
    localparam int CS_DELAY_CLKS = (CS_DELAY_NS + NS_PER_CLK - 1) / NS_PER_CLK;

    // Clocks per sck period, rounded up and then made even
    // This keeps sck at or below the requested rate
    localparam int CLK_PER_SCK      = (clk_freq_hz + sck_freq_hz - 1) / sck_freq_hz;
    localparam int EVEN_CLK_PER_SCK = CLK_PER_SCK + (CLK_PER_SCK % 2);

    // Each half period lasts HALF_DELAY plus one clock
    localparam int HALF_DELAY = (EVEN_CLK_PER_SCK > 2) ? (EVEN_CLK_PER_SCK / 2) - 1 : 0;

    localparam int TIMER_MAX = (CS_DELAY_CLKS > HALF_DELAY) ? CS_DELAY_CLKS : HALF_DELAY;
    localparam int TIMER_W   = (TIMER_MAX > 0) ? $clog2(TIMER_MAX + 1) : 1;

    // Frame lengths in nybbles
    localparam int WRITE_NYBBLES = OPCODE_NYBBLES + ADDR_NYBBLES + DATA_NYBBLES;
    localparam int READ_NYBBLES  = WRITE_NYBBLES + TAT_NYBBLES;
    localparam int COUNT_W       = $clog2(READ_NYBBLES + 1);

    // Opcode, address and one data word
    localparam int SHIFT_W = 4 * WRITE_NYBBLES;

    // ============================================================
    // State and datapath registers
    // ============================================================

    typedef enum logic [2:0] {
        st_idle,
        st_assert_cs,
        st_falling_sck,
        st_rising_sck,
        st_release_cs,
        st_wait_complete
    } engine_state_t;

    engine_state_t      state;
    logic [TIMER_W-1:0] timer;
    logic [COUNT_W-1:0] nybble_count;
    logic [COUNT_W-1:0] nybble_total;
    logic [SHIFT_W-1:0] shift_word;
    logic [31:0]        miso_shift;

    // A start in this cycle already counts as busy
    assign frame_idle = (state == st_idle) && !frame_start;

    // Read data arrives little-endian, most significant nybble first
    assign read_word = swap_bytes(miso_shift);

    // ============================================================
    // Frame state machine
    // ============================================================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= st_idle;
            timer    <= '0;
            sck      <= 1'b0;
            mosi     <= 4'h0;
            host_csn <= 1'b1;
            bank_csn <= 1'b1;
        end else begin
            // Shared countdown; states below reload it where needed
            if (timer != '0) begin
                timer <= timer - 1'b1;
            end

            case (state)
                st_idle: begin
                    if (frame_start) begin
                        // Only the addressed chip select drops
                        host_csn     <= (frame.target != cs_host);
                        bank_csn     <= (frame.target != cs_bank);
                        sck          <= 1'b0;
                        timer        <= TIMER_W'(CS_DELAY_CLKS);
                        nybble_count <= '0;
                        // The data slot stays zero for reads, which covers the
                        // turnaround and read data phases once it shifts out
                        if (frame.is_read) begin
                            nybble_total <= COUNT_W'(READ_NYBBLES);
                            shift_word   <= {spread_opcode(OPCODE_READ_SINGLE),
                                             swap_bytes(frame.address), 32'h0};
                        end else begin
                            nybble_total <= COUNT_W'(WRITE_NYBBLES);
                            shift_word   <= {spread_opcode(OPCODE_WRITE_SINGLE),
                                             swap_bytes(frame.address),
                                             swap_bytes(frame.wdata)};
                        end
                        state <= st_assert_cs;
                    end
                end

                // Chip-select setup time
                st_assert_cs: begin
                    if (timer == '0) begin
                        state <= st_falling_sck;
                    end
                end

                // sck low and the next nybble out on mosi
                st_falling_sck: begin
                    if (timer == '0) begin
                        sck        <= 1'b0;
                        mosi       <= shift_word[SHIFT_W-1 -: 4];
                        shift_word <= shift_word << 4;
                        if (nybble_count < nybble_total) begin
                            timer <= TIMER_W'(HALF_DELAY);
                            state <= st_rising_sck;
                        end else begin
                            state <= st_release_cs;
                        end
                    end
                end

                // sck high; the receiver takes mosi and we take miso on this edge
                st_rising_sck: begin
                    if (timer == '0) begin
                        sck          <= 1'b1;
                        miso_shift   <= {miso_shift[27:0], miso};
                        nybble_count <= nybble_count + 1'b1;
                        timer        <= TIMER_W'(HALF_DELAY);
                        state        <= st_falling_sck;
                    end
                end

                st_release_cs: begin
                    host_csn <= 1'b1;
                    bank_csn <= 1'b1;
                    mosi     <= 4'h0;
                    timer    <= TIMER_W'(CS_DELAY_CLKS);
                    state    <= st_wait_complete;
                end

                // Chip-select hold time before the next frame may start
                st_wait_complete: begin
                    if (timer == '0) begin
                        state <= st_idle;
                    end
                end

                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- source/qspi_manager.sv
// QSPI manager top level: command sequencer feeding the frame engine
`timescale 1ns/1ns

module qspi_manager #(
    parameter int clk_freq_hz = 100_000_000,
    parameter int sck_freq_hz = 50_000_000
) (
    input  logic                    clk,
    input  logic                    resetn,
    input  qspi_cmd_pkg::qspi_req_t req,
    output qspi_cmd_pkg::qspi_rsp_t rsp,
    output logic [3:0]              mosi,
    input  logic [3:0]              miso,
    output logic                    sck,
    output logic                    host_csn,
    output logic                    bank_csn
);

    import qspi_wire_pkg::*;

    // Sequencer to engine
    qspi_frame_t frame;
    logic        frame_start;
    logic        frame_idle;
    logic [31:0] read_word;

    qspi_command_sequencer qspi_command_sequencer_i (
        .clk         (clk),
        .resetn      (resetn),
        .req         (req),
        .rsp         (rsp),
        .frame       (frame),
        .frame_start (frame_start),
        .frame_idle  (frame_idle),
        .read_word   (read_word)
    );

    // Only the engine needs the clock rates
    qspi_frame_engine #(
        .clk_freq_hz (clk_freq_hz),
        .sck_freq_hz (sck_freq_hz)
    ) qspi_frame_engine_i (
        .clk         (clk),
        .resetn      (resetn),
        .frame       (frame),
        .frame_start (frame_start),
        .frame_idle  (frame_idle),
        .read_word   (read_word),
        .sck         (sck),
        .mosi        (mosi),
        .miso        (miso),
        .host_csn    (host_csn),
        .bank_csn    (bank_csn)
    );

endmodule

//--- source/qspi_wire_pkg.sv
// Wire-level QSPI definitions for the GenX receiver: chip selects, frame type,
// opcodes, phase lengths and the opcode and byte-order helpers
package qspi_wire_pkg;

    // Which of the two chip-select pins a frame drives
    typedef enum logic {
        cs_host = 1'b0,
        cs_bank = 1'b1
    } cs_sel_t;

    // One frame as handed from the sequencer to the engine
    typedef struct packed {
        cs_sel_t     target;
        logic        is_read;
        logic [31:0] address;
        logic [31:0] wdata;
    } qspi_frame_t;

    // Single-word opcodes understood by the GenX QSPI receiver
    localparam logic [7:0] OPCODE_READ_SINGLE  = 8'hE8;
    localparam logic [7:0] OPCODE_WRITE_SINGLE = 8'hE9;

    // Host register that enables banks for bank accesses
    localparam logic [31:0] BANK_EN_REG = 32'h28;

    // Chip-select setup and hold time in ns
    localparam int CS_DELAY_NS = 60;

    // Phase lengths in nybbles; turnaround only exists in read frames
    localparam int OPCODE_NYBBLES = 8;
    localparam int ADDR_NYBBLES   = 8;
    localparam int DATA_NYBBLES   = 8;
    localparam int TAT_NYBBLES    = 16;

    // Each opcode bit lands in bit 0 of its own nybble, bit 7 in the top nybble
    function automatic logic [31:0] spread_opcode(input logic [7:0] opcode);
        logic [31:0] result;
        result = '0;
        for (int i = 0; i < 8; i++) begin
            result[4*i] = opcode[i];
        end
        return result;
    endfunction

    // Byte reversal, used for the little-endian address and data on the wire
    function automatic logic [31:0] swap_bytes(input logic [31:0] value);
        return {value[7:0], value[15:8], value[23:16], value[31:24]};
    endfunction

endpackage
